// File: hw/bp_pkg.sv
package bp_pkg;

    // Instruction address width
    localparam int ADDR_W = 32;

    ////////////////////////////////////////////////////////////////////////////
    // Direction counter
    ////////////////////////////////////////////////////////////////////////////

    // Two-bit saturating counter where the upper half predicts taken
    typedef enum logic [1:0] {
        DIR_SNT = 2'b00,    // Strongly not taken
        DIR_WNT = 2'b01,    // Weakly not taken and the reset state
        DIR_WT  = 2'b10,    // Weakly taken
        DIR_ST  = 2'b11     // Strongly taken
    } dir_state_e;

    ////////////////////////////////////////////////////////////////////////////
    // Branch type
    ////////////////////////////////////////////////////////////////////////////

    // Stored per BTB entry and handed back with the target.
    // BR_COND doubles as the zero value on a miss
    typedef enum logic [1:0] {
        BR_COND = 2'b00,    // Conditional branch
        BR_JUMP = 2'b01,    // Unconditional jump
        BR_CALL = 2'b10,    // Call that links a return address
        BR_RET  = 2'b11     // Return
    } branch_type_e;

endpackage

// File: hw/btb_array.sv
`timescale 1ns/1ps

module btb_array
    import bp_pkg::*;
#(
    parameter int INDEX_BITS = 8
) (
    input  logic               clk,
    input  logic               rst_n_i,

    // Lookup addresses for both fetch slots
    input  logic [ADDR_W-1:0]  pc0_i,
    input  logic [ADDR_W-1:0]  pc1_i,

    // Resolved branch from execute
    input  logic               upd_valid_i,
    input  logic [ADDR_W-1:0]  upd_pc_i,
    input  logic [ADDR_W-1:0]  upd_target_i,
    input  branch_type_e       upd_type_i,

    // Slot 0 results
    output logic               hit0_o,
    output logic [ADDR_W-1:0]  target0_o,
    output branch_type_e       type0_o,

    // Slot 1 results
    output logic               hit1_o,
    output logic [ADDR_W-1:0]  target1_o,
    output branch_type_e       type1_o
);

    localparam int DEPTH = 1 << INDEX_BITS;
    localparam int TAG_W = ADDR_W - INDEX_BITS - 2;

    ////////////////////////////////////////////////////////////////////////////
    // Address split
    ////////////////////////////////////////////////////////////////////////////

    logic [INDEX_BITS-1:0] idx0;
    logic [INDEX_BITS-1:0] idx1;
    logic [INDEX_BITS-1:0] upd_idx;
    logic [TAG_W-1:0]      tag0;
    logic [TAG_W-1:0]      tag1;
    logic [TAG_W-1:0]      upd_tag;

    // Bits 1:0 are always zero for word-aligned instructions
    assign idx0    = pc0_i[INDEX_BITS+1:2];
    assign idx1    = pc1_i[INDEX_BITS+1:2];
    assign upd_idx = upd_pc_i[INDEX_BITS+1:2];

    assign tag0    = pc0_i[ADDR_W-1:INDEX_BITS+2];
    assign tag1    = pc1_i[ADDR_W-1:INDEX_BITS+2];
    assign upd_tag = upd_pc_i[ADDR_W-1:INDEX_BITS+2];

    ////////////////////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////////////////////

    logic [TAG_W-1:0]  tag_mem    [DEPTH];
    logic [ADDR_W-1:0] target_mem [DEPTH];
    branch_type_e      type_mem   [DEPTH];
    logic [DEPTH-1:0]  valid_q;

    // Entry only counts as valid with a real target behind it
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (upd_valid_i) begin
            valid_q[upd_idx] <= |upd_target_i;
        end
    end

    always_ff @(posedge clk) begin
        if (upd_valid_i) begin
            tag_mem[upd_idx]    <= upd_tag;
            target_mem[upd_idx] <= upd_target_i;
            type_mem[upd_idx]   <= upd_type_i;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Lookup
    ////////////////////////////////////////////////////////////////////////////

    // Same-cycle update is not forwarded, old contents until the edge
    assign hit0_o    = valid_q[idx0] && (tag_mem[idx0] == tag0);
    assign target0_o = hit0_o ? target_mem[idx0] : '0;
    assign type0_o   = hit0_o ? type_mem[idx0] : BR_COND;

    assign hit1_o    = valid_q[idx1] && (tag_mem[idx1] == tag1);
    assign target1_o = hit1_o ? target_mem[idx1] : '0;
    assign type1_o   = hit1_o ? type_mem[idx1] : BR_COND;

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    a_upd_aligned: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        upd_valid_i |-> (upd_pc_i[1:0] == 2'b00)
    );

    // Valid bit and stored target are written together on the update edge
    a_hit0_target: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        hit0_o |-> (target0_o != '0)
    );

    a_hit1_target: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        hit1_o |-> (target1_o != '0)
    );

endmodule

// File: hw/direction_table.sv
`timescale 1ns/1ps

module direction_table
    import bp_pkg::*;
#(
    parameter int INDEX_BITS = 8
) (
    input  logic               clk,
    input  logic               rst_n_i,

    // Lookup addresses, only the index bits matter here
    input  logic [ADDR_W-1:0]  pc0_i,
    input  logic [ADDR_W-1:0]  pc1_i,

    // Resolved direction from execute
    input  logic               upd_valid_i,
    input  logic [ADDR_W-1:0]  upd_pc_i,
    input  logic               upd_taken_i,

    output logic               taken0_o,
    output logic               taken1_o
);

    localparam int DEPTH = 1 << INDEX_BITS;

    logic [INDEX_BITS-1:0] idx0;
    logic [INDEX_BITS-1:0] idx1;
    logic [INDEX_BITS-1:0] upd_idx;

    assign idx0    = pc0_i[INDEX_BITS+1:2];
    assign idx1    = pc1_i[INDEX_BITS+1:2];
    assign upd_idx = upd_pc_i[INDEX_BITS+1:2];

    ////////////////////////////////////////////////////////////////////////////
    // Counter array
    ////////////////////////////////////////////////////////////////////////////

    // No tags, aliasing branches share a counter
    dir_state_e cnt_q [DEPTH];
    dir_state_e cnt_next;

    // One step towards the actual outcome, saturating at both ends
    always_comb begin
        case (cnt_q[upd_idx])
            DIR_SNT: cnt_next = upd_taken_i ? DIR_WNT : DIR_SNT;
            DIR_WNT: cnt_next = upd_taken_i ? DIR_WT  : DIR_SNT;
            DIR_WT:  cnt_next = upd_taken_i ? DIR_ST  : DIR_WNT;
            DIR_ST:  cnt_next = upd_taken_i ? DIR_ST  : DIR_WT;
            default: cnt_next = DIR_WNT;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                cnt_q[i] <= DIR_WNT;    // Start weakly not taken
            end
        end else if (upd_valid_i) begin
            cnt_q[upd_idx] <= cnt_next;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Lookup
    ////////////////////////////////////////////////////////////////////////////

    assign taken0_o = cnt_q[idx0] inside {DIR_WT, DIR_ST};
    assign taken1_o = cnt_q[idx1] inside {DIR_WT, DIR_ST};

    // An X here would spread into the counter and stay there
    a_taken_known: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        upd_valid_i |-> !$isunknown(upd_taken_i)
    );

endmodule

// File: hw/branch_predictor.sv
`timescale 1ns/1ps

module branch_predictor
    import bp_pkg::*;
#(
    parameter int INDEX_BITS = 8
) (
    input  logic               clk,
    input  logic               rst_n_i,

    // Fetch side
    input  logic [ADDR_W-1:0]  fetch_pc_i,

    // Execute side, one resolved branch per cycle
    input  logic               upd_valid_i,
    input  logic [ADDR_W-1:0]  upd_pc_i,
    input  logic               upd_taken_i,
    input  logic [ADDR_W-1:0]  upd_target_i,
    input  branch_type_e       upd_type_i,

    // Slot 0 prediction
    output logic               pred_hit0_o,
    output logic               pred_taken0_o,
    output logic [ADDR_W-1:0]  pred_target0_o,
    output branch_type_e       pred_type0_o,

    // Slot 1 prediction
    output logic               pred_hit1_o,
    output logic               pred_taken1_o,
    output logic [ADDR_W-1:0]  pred_target1_o,
    output branch_type_e       pred_type1_o
);

    ////////////////////////////////////////////////////////////////////////////
    // Slot addresses
    ////////////////////////////////////////////////////////////////////////////

    logic [ADDR_W-1:0] pc0;
    logic [ADDR_W-1:0] pc1;

    assign pc0 = fetch_pc_i;
    assign pc1 = fetch_pc_i + ADDR_W'(4);   // Second instruction of the pair

    logic btb_hit0;
    logic btb_hit1;
    logic dir_taken0;
    logic dir_taken1;

    ////////////////////////////////////////////////////////////////////////////
    // Tables
    ////////////////////////////////////////////////////////////////////////////

    btb_array #(
        .INDEX_BITS   (INDEX_BITS)
    ) u_btb (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .pc0_i        (pc0),
        .pc1_i        (pc1),
        .upd_valid_i  (upd_valid_i),
        .upd_pc_i     (upd_pc_i),
        .upd_target_i (upd_target_i),
        .upd_type_i   (upd_type_i),
        .hit0_o       (btb_hit0),
        .target0_o    (pred_target0_o),   // Already zero on a miss
        .type0_o      (pred_type0_o),
        .hit1_o       (btb_hit1),
        .target1_o    (pred_target1_o),
        .type1_o      (pred_type1_o)
    );

    direction_table #(
        .INDEX_BITS   (INDEX_BITS)
    ) u_dir (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .pc0_i        (pc0),
        .pc1_i        (pc1),
        .upd_valid_i  (upd_valid_i),
        .upd_pc_i     (upd_pc_i),
        .upd_taken_i  (upd_taken_i),
        .taken0_o     (dir_taken0),
        .taken1_o     (dir_taken1)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Per-slot gating
    ////////////////////////////////////////////////////////////////////////////

    // Untagged counter only counts once the BTB confirms a branch
    assign pred_hit0_o   = btb_hit0;
    assign pred_taken0_o = btb_hit0 & dir_taken0;
    assign pred_hit1_o   = btb_hit1;
    assign pred_taken1_o = btb_hit1 & dir_taken1;

    a_fetch_aligned: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        fetch_pc_i[1:0] == 2'b00
    );

endmodule

// File: testbench/bp_model.svh
`ifndef BP_MODEL_SVH
`define BP_MODEL_SVH

////////////////////////////////////////////////////////////////////////////
// Mirror of BTB entries and direction counters
////////////////////////////////////////////////////////////////////////////

logic [TAG_W-1:0]  mirror_tag    [1 << INDEX_BITS];
logic [ADDR_W-1:0] mirror_target [1 << INDEX_BITS];
branch_type_e      mirror_type   [1 << INDEX_BITS];
logic              mirror_valid  [1 << INDEX_BITS];
dir_state_e        mirror_cnt    [1 << INDEX_BITS];

function automatic int unsigned index_of(input logic [ADDR_W-1:0] pc);
    return pc[INDEX_BITS+1:2];     // Word index above the byte offset
endfunction

function automatic logic [TAG_W-1:0] tag_of(input logic [ADDR_W-1:0] pc);
    return pc[ADDR_W-1:INDEX_BITS+2];
endfunction

function automatic void clear_mirror();
    for (int i = 0; i < (1 << INDEX_BITS); i++) begin
        mirror_valid[i] = 1'b0;
        mirror_cnt[i]   = DIR_WNT;
    end
endfunction

function automatic void apply_update(input logic [ADDR_W-1:0] pc, input logic taken,
                                     input logic [ADDR_W-1:0] target, input branch_type_e ty);
    int unsigned i;
    i = index_of(pc);
    mirror_tag[i]    = tag_of(pc);
    mirror_target[i] = target;
    mirror_type[i]   = ty;
    mirror_valid[i]  = (target != '0);   // Zero target never allocates
    if (taken && mirror_cnt[i] != DIR_ST)
        mirror_cnt[i] = dir_state_e'(mirror_cnt[i] + 1);
    else if (!taken && mirror_cnt[i] != DIR_SNT)
        mirror_cnt[i] = dir_state_e'(mirror_cnt[i] - 1);
endfunction

function automatic void predict_slot(input logic [ADDR_W-1:0] pc, output logic hit,
                                     output logic taken, output logic [ADDR_W-1:0] target,
                                     output branch_type_e ty);
    int unsigned i;
    i      = index_of(pc);
    hit    = mirror_valid[i] && (mirror_tag[i] == tag_of(pc));
    taken  = hit && (mirror_cnt[i] == DIR_WT || mirror_cnt[i] == DIR_ST);
    target = hit ? mirror_target[i] : '0;
    ty     = hit ? mirror_type[i] : BR_COND;
endfunction

`endif

// File: testbench/tb_branch_predictor.sv
`timescale 1ns/1ps

module tb_branch_predictor
    import bp_pkg::*;
();

    localparam int INDEX_BITS = 8;
    localparam int TAG_W      = ADDR_W - INDEX_BITS - 2;

    // Phase lengths in cycles
    localparam int RESET_CYCLES = 5;
    localparam int N_IDLE       = 40;
    localparam int N_ALLOC      = 16;   // Three cycles per entry
    localparam int N_ZERO       = 8;    // Two cycles per entry
    localparam int N_RANDOM     = 2000;
    localparam int CYCLE_LIMIT  = RESET_CYCLES + N_IDLE + 3 * N_ALLOC + 2 * N_ZERO
                                  + 14 + 8 + N_RANDOM + 2 + 100;

    logic               clk;
    logic               rst_n_i;
    logic [ADDR_W-1:0]  fetch_pc_i;
    logic               upd_valid_i;
    logic [ADDR_W-1:0]  upd_pc_i;
    logic               upd_taken_i;
    logic [ADDR_W-1:0]  upd_target_i;
    branch_type_e       upd_type_i;
    logic               pred_hit0_o;
    logic               pred_taken0_o;
    logic               pred_hit1_o;
    logic               pred_taken1_o;
    logic [ADDR_W-1:0]  pred_target0_o;
    logic [ADDR_W-1:0]  pred_target1_o;
    branch_type_e       pred_type0_o;
    branch_type_e       pred_type1_o;

    int check_count  = 0;
    int slot0_errors = 0;
    int slot1_errors = 0;
    int cycle_count  = 0;

    // Small pools so hits, aliasing and tag conflicts happen often
    logic [TAG_W-1:0]      tag_pool [4] = '{22'h0, 22'h1, 22'h2ab, 22'h3fffff};
    logic [INDEX_BITS-1:0] idx_pool [8] = '{8'h00, 8'h01, 8'h02, 8'h03,
                                           8'h7e, 8'h7f, 8'hfe, 8'hff};

    `include "bp_model.svh"

    branch_predictor #(
        .INDEX_BITS (INDEX_BITS)
    ) DUT (.*);

    always #4 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [ADDR_W-1:0] random_pc();
        return {tag_pool[$urandom % 4], idx_pool[$urandom % 8], 2'b00};
    endfunction

    function automatic logic [ADDR_W-1:0] random_target();
        logic [ADDR_W-1:0] t;
        t = $urandom;
        t[1:0] = 2'b00;
        if (t == '0)
            t = 32'h100;
        return t;
    endfunction

    task automatic step_cycle(input logic [ADDR_W-1:0] fpc, input logic uv,
                              input logic [ADDR_W-1:0] upc, input logic tk,
                              input logic [ADDR_W-1:0] tgt, input branch_type_e ty);
        @(posedge clk);
        #1;
        fetch_pc_i   = fpc;
        upd_valid_i  = uv;
        upd_pc_i     = upc;
        upd_taken_i  = tk;
        upd_target_i = tgt;
        upd_type_i   = ty;
    endtask

    task automatic fetch_only(input logic [ADDR_W-1:0] fpc);
        step_cycle(fpc, 1'b0, '0, 1'b0, '0, BR_COND);
    endtask

    task automatic compare_value(input string name, input logic [ADDR_W-1:0] exp_v,
                                 input logic [ADDR_W-1:0] act_v, input int slot);
        check_count++;
        assert (act_v === exp_v)
        else begin
            $display("ERR %0t %s expected %h actual %h", $time, name, exp_v, act_v);
            if (slot == 0)
                slot0_errors++;
            else
                slot1_errors++;
        end
    endtask

    task automatic check_outputs();
        logic e_hit;
        logic e_taken;
        logic [ADDR_W-1:0] e_target;
        branch_type_e e_type;
        predict_slot(fetch_pc_i, e_hit, e_taken, e_target, e_type);
        compare_value("pred_hit0_o", e_hit, pred_hit0_o, 0);
        compare_value("pred_taken0_o", e_taken, pred_taken0_o, 0);
        compare_value("pred_target0_o", e_target, pred_target0_o, 0);
        compare_value("pred_type0_o", e_type, pred_type0_o, 0);
        predict_slot(fetch_pc_i + 4, e_hit, e_taken, e_target, e_type);
        compare_value("pred_hit1_o", e_hit, pred_hit1_o, 1);
        compare_value("pred_taken1_o", e_taken, pred_taken1_o, 1);
        compare_value("pred_target1_o", e_target, pred_target1_o, 1);
        compare_value("pred_type1_o", e_type, pred_type1_o, 1);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Model tracking, checking and timeout
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (!rst_n_i)
            clear_mirror();
        else if (upd_valid_i)
            apply_update(upd_pc_i, upd_taken_i, upd_target_i, upd_type_i);
    end

    always @(negedge clk) begin
        if (rst_n_i)
            check_outputs();    // Inputs settled since edge plus 1 ns
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, stimulus did not finish", CYCLE_LIMIT);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic [ADDR_W-1:0] pc;
        logic [ADDR_W-1:0] pcb;
        logic [ADDR_W-1:0] tgt;
        logic [ADDR_W-1:0] upc;
        void'($urandom(11));
        clk = 1'b0;
        rst_n_i = 1'b0;
        fetch_pc_i = '0;
        upd_valid_i = 1'b0;
        upd_pc_i = '0;
        upd_taken_i = 1'b0;
        upd_target_i = '0;
        upd_type_i = BR_COND;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n_i = 1'b1;

        repeat (N_IDLE) fetch_only(random_pc());   // Empty tables

        // Allocate, then look up on slot 0 and on slot 1
        repeat (N_ALLOC) begin
            pc = random_pc();
            step_cycle(pc, 1'b1, pc, 1'($urandom), random_target(),
                       branch_type_e'(2'($urandom)));
            fetch_only(pc);
            fetch_only(pc - 4);
        end

        repeat (N_ZERO) begin
            pc = random_pc();
            step_cycle(pc, 1'b1, pc, 1'b1, '0, BR_JUMP);
            fetch_only(pc);
        end

        // Walk one counter up into saturation and back down
        pc  = {tag_pool[1], idx_pool[2], 2'b00};
        tgt = random_target();
        repeat (7) step_cycle(pc, 1'b1, pc, 1'b1, tgt, BR_COND);
        repeat (6) step_cycle(pc, 1'b1, pc, 1'b0, tgt, BR_COND);
        fetch_only(pc);

        // Second tag at the same index shares the counter
        pc  = {tag_pool[0], idx_pool[4], 2'b00};
        pcb = {tag_pool[3], idx_pool[4], 2'b00};
        step_cycle(pc, 1'b1, pc, 1'b1, random_target(), BR_CALL);
        step_cycle(pc, 1'b1, pcb, 1'b1, random_target(), BR_RET);
        fetch_only(pc);
        fetch_only(pcb);
        step_cycle(pcb, 1'b1, pcb, 1'b0, random_target(), BR_RET);
        step_cycle(pcb, 1'b1, pcb, 1'b0, random_target(), BR_RET);
        step_cycle(pcb, 1'b1, pcb, 1'b1, random_target(), BR_RET);
        fetch_only(pcb);

        repeat (N_RANDOM) begin
            pc  = random_pc();
            upc = ($urandom % 4 == 0) ? pc : random_pc();   // Same-index collisions
            tgt = ($urandom % 8 == 0) ? '0 : random_target();
            step_cycle(pc, 1'($urandom), upc, 1'($urandom), tgt, branch_type_e'(2'($urandom)));
        end

        fetch_only('0);
        @(negedge clk);
        #1;
        $display("Checks %0d, slot 0 errors %0d, slot 1 errors %0d",
                 check_count, slot0_errors, slot1_errors);
        if (slot0_errors == 0 && slot1_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+testbench
hw/bp_pkg.sv
hw/btb_array.sv
hw/direction_table.sv
hw/branch_predictor.sv
testbench/tb_branch_predictor.sv

// File: Bender.yml
package:
  name: branch_predictor

sources:
  - files:
      - hw/bp_pkg.sv
      - hw/btb_array.sv
      - hw/direction_table.sv
      - hw/branch_predictor.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_branch_predictor.sv
